/* hdl/frac_cen.sv */
/* Fractional n/m clock-enable generator
   cen[0] runs at n/m of clk, each higher bit at half the bit below */

`timescale 1ns/10ps

module frac_cen import kicker_pkg::*; #(
    parameter int CEN_N = 32,
    parameter int CEN_M = 125
) (
    input  logic     clk,
    input  logic     rst,
    output cen_vec_t cen
);

    // Wide enough for acc + CEN_N before the wrap
    localparam int ACC_W = $clog2(CEN_N + CEN_M + 1);

    localparam logic [ACC_W-1:0] STEP = ACC_W'(CEN_N);
    localparam logic [ACC_W-1:0] WRAP = ACC_W'(CEN_M);

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_sum;
    logic             pulse;
    logic [2:0]       div_cnt;  // Counts cen[0] pulses

    assign acc_sum = acc + STEP;
    assign pulse   = acc_sum >= WRAP;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc     <= '0;
            div_cnt <= '0;
            cen     <= '0;
        end else begin
            acc <= pulse ? acc_sum - WRAP : acc_sum;
            if (pulse) begin
                div_cnt <= div_cnt + 3'd1;
            end
            // Each bit fires on every second pulse of the one below
            cen[0] <= pulse;
            cen[1] <= pulse & div_cnt[0];
            cen[2] <= pulse & (&div_cnt[1:0]);
            cen[3] <= pulse & (&div_cnt);
        end
    end

endmodule

/* hdl/kicker_mem.sv */
/* Kicker memory and timing plane
   Clock enables, ROM download path and the SDRAM read arbiter */

`timescale 1ns/10ps

module kicker_mem import kicker_pkg::*; #(
    parameter int SCR_START  = 'h10000,
    parameter int OBJ_START  = 'h14000,
    parameter int PROM_START = 'h34000,
    parameter int CEN_N      = 32,     // 48 MHz * 32/125 ~ 12.3 MHz
    parameter int CEN_M      = 125
) (
    input  logic        clk,
    input  logic        rst,
    output cen_vec_t    cen,
    // Loader
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_dout,
    input  logic        ioctl_wr,
    // SDRAM programming
    output sdram_addr_t prog_addr,
    output byte_t       prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    // Colour PROMs
    output logic        prom_we,
    output prom_addr_t  prom_addr,
    // ROM clients
    input  logic        slot0_cs,
    input  logic [12:0] slot0_addr,
    output logic        slot0_ok,
    output word_t       slot0_dout,
    input  logic        slot1_cs,
    input  logic [16:0] slot1_addr,
    output logic        slot1_ok,
    output byte_t       slot1_dout,
    input  logic        slot2_cs,
    input  logic [15:0] slot2_addr,
    output logic        slot2_ok,
    output byte_t       slot2_dout,
    // SDRAM read port
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_dst,
    input  logic        data_rdy,
    input  word_t       data_read
);

    frac_cen #(.CEN_N(CEN_N), .CEN_M(CEN_M)) u_cen (
        .clk ( clk ),
        .rst ( rst ),
        .cen ( cen )
    );

    rom_dwnld #(
        .SCR_START  ( SCR_START  ),
        .OBJ_START  ( OBJ_START  ),
        .PROM_START ( PROM_START )
    ) u_dwnld (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),  // Shared, reads are idle while downloading
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   )
    );

    rom_arbiter #(.SCR_START(SCR_START), .OBJ_START(OBJ_START)) u_rom (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .slot0_cs    ( slot0_cs    ),
        .slot0_addr  ( slot0_addr  ),
        .slot0_ok    ( slot0_ok    ),
        .slot0_dout  ( slot0_dout  ),
        .slot1_cs    ( slot1_cs    ),
        .slot1_addr  ( slot1_addr  ),
        .slot1_ok    ( slot1_ok    ),
        .slot1_dout  ( slot1_dout  ),
        .slot2_cs    ( slot2_cs    ),
        .slot2_addr  ( slot2_addr  ),
        .slot2_ok    ( slot2_ok    ),
        .slot2_dout  ( slot2_dout  ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

/* hdl/kicker_pkg.sv */
/* Kicker memory plane shared definitions
   Bus widths, PROM region size and the ROM arbiter states */

package kicker_pkg;

    // Loader byte address from the ioctl port
    typedef logic [24:0] ioctl_addr_t;

    // SDRAM address in 16-bit words
    typedef logic [21:0] sdram_addr_t;

    typedef logic [7:0]  byte_t;   // Loader and client bytes
    typedef logic [15:0] word_t;   // SDRAM data word

    // Clock enables
    // bit 0 pxl2 12 MHz, bit 1 pxl 6 MHz, bit 2 3 MHz, bit 3 1.5 MHz
    typedef logic [3:0]  cen_vec_t;

    // Colour PROM byte address
    typedef logic [10:0] prom_addr_t;

    // Bytes in the colour PROM region, matches prom_addr_t
    localparam int PROM_SIZE = 2048;

    // ROM read clients on the shared SDRAM port
    localparam int NUM_SLOTS = 3;

    // SDRAM read scheduler
    typedef enum logic [1:0] {
        IDLE,       // Pick the next pending slot
        REQUEST,    // sdram_req held until ack
        WAIT_DST,   // Burst not started yet
        WAIT_RDY    // Data on its way
    } arb_state_t;

endpackage

/* hdl/rom_arbiter.sv */
/* Three ROM read slots sharing one SDRAM read port
   Fixed priority, main first, then scroll, then objects */

`timescale 1ns/10ps

module rom_arbiter import kicker_pkg::*; #(
    parameter int SCR_START = 'h10000,
    parameter int OBJ_START = 'h14000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    // Scroll tiles
    input  logic        slot0_cs,
    input  logic [12:0] slot0_addr,
    output logic        slot0_ok,
    output word_t       slot0_dout,
    // Objects
    input  logic        slot1_cs,
    input  logic [16:0] slot1_addr,
    output logic        slot1_ok,
    output byte_t       slot1_dout,
    // Main CPU
    input  logic        slot2_cs,
    input  logic [15:0] slot2_addr,
    output logic        slot2_ok,
    output byte_t       slot2_dout,
    // SDRAM read port
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_dst,
    input  logic        data_rdy,
    input  word_t       data_read
);

    logic [NUM_SLOTS-1:0] slot_req;
    logic [NUM_SLOTS-1:0] slot_rdy;
    logic [NUM_SLOTS-1:0] grant;     // One-hot, slot being served
    logic [NUM_SLOTS-1:0] pick;
    sdram_addr_t          slot_addr [NUM_SLOTS];
    sdram_addr_t          pick_addr;
    arb_state_t           state;
    logic                 in_read;

    rom_slot #(.DW(16), .AW(13), .OFFSET(SCR_START/2)) u_scr (
        .clk       ( clk          ),
        .rst       ( rst          ),
        .clear     ( downloading  ),
        .cs        ( slot0_cs     ),
        .addr      ( slot0_addr   ),
        .data_read ( data_read    ),
        .grant_rdy ( slot_rdy[0]  ),
        .req       ( slot_req[0]  ),
        .req_addr  ( slot_addr[0] ),
        .ok        ( slot0_ok     ),
        .dout      ( slot0_dout   )
    );

    rom_slot #(.DW(8), .AW(17), .OFFSET(OBJ_START/2)) u_obj (
        .clk       ( clk          ),
        .rst       ( rst          ),
        .clear     ( downloading  ),
        .cs        ( slot1_cs     ),
        .addr      ( slot1_addr   ),
        .data_read ( data_read    ),
        .grant_rdy ( slot_rdy[1]  ),
        .req       ( slot_req[1]  ),
        .req_addr  ( slot_addr[1] ),
        .ok        ( slot1_ok     ),
        .dout      ( slot1_dout   )
    );

    rom_slot #(.DW(8), .AW(16), .OFFSET(0)) u_main (
        .clk       ( clk          ),
        .rst       ( rst          ),
        .clear     ( downloading  ),
        .cs        ( slot2_cs     ),
        .addr      ( slot2_addr   ),
        .data_read ( data_read    ),
        .grant_rdy ( slot_rdy[2]  ),
        .req       ( slot_req[2]  ),
        .req_addr  ( slot_addr[2] ),
        .ok        ( slot2_ok     ),
        .dout      ( slot2_dout   )
    );

    assign in_read  = state == WAIT_DST || state == WAIT_RDY;
    assign slot_rdy = grant & {NUM_SLOTS{data_rdy & in_read}};

    // Main CPU stalls hardest on a miss, so it goes first
    always_comb begin
        pick      = '0;
        pick_addr = slot_addr[2];
        if (slot_req[2]) begin
            pick = 3'b100;
        end else if (slot_req[0]) begin
            pick      = 3'b001;
            pick_addr = slot_addr[0];
        end else if (slot_req[1]) begin
            pick      = 3'b010;
            pick_addr = slot_addr[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            grant     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!downloading && |slot_req) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        state     <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= WAIT_DST;
                    end
                end
                WAIT_DST: begin
                    if (data_rdy) begin
                        state <= IDLE;   // Single-word burst
                    end else if (data_dst) begin
                        state <= WAIT_RDY;
                    end
                end
                WAIT_RDY: begin
                    if (data_rdy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            sdram_addr <= pick_addr;   // Frozen for the whole request
        end
    end

endmodule

/* hdl/rom_dwnld.sv */
/* ROM download path, loader bytes to SDRAM programming writes
   Scroll region address swizzle, byte mask and colour PROM diversion */

`timescale 1ns/10ps

module rom_dwnld import kicker_pkg::*; #(
    parameter int SCR_START  = 'h10000,
    parameter int OBJ_START  = 'h14000,
    parameter int PROM_START = 'h34000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_dout,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output sdram_addr_t prog_addr,
    output byte_t       prog_data,
    output logic [1:0]  prog_mask,   // Active low
    output logic        prog_we,
    output logic        prom_we,
    output prom_addr_t  prom_addr
);

    sdram_addr_t word_addr;
    sdram_addr_t swz_addr;
    ioctl_addr_t prom_ofs;
    logic        in_scr;
    logic        in_prom;
    logic        prom_fits;
    logic        wr_en;

    assign wr_en     = ioctl_wr & downloading;
    assign word_addr = ioctl_addr[22:1];
    assign in_scr    = ioctl_addr >= ioctl_addr_t'(SCR_START) &&
                       ioctl_addr <  ioctl_addr_t'(OBJ_START);
    assign in_prom   = ioctl_addr >= ioctl_addr_t'(PROM_START);
    assign prom_ofs  = ioctl_addr - ioctl_addr_t'(PROM_START);
    assign prom_fits = prom_ofs < ioctl_addr_t'(PROM_SIZE);

    // Tile rows are interleaved on the board, rotate the low nibble
    always_comb begin
        swz_addr = word_addr;
        if (in_scr) begin
            swz_addr[0]   = ~word_addr[3];
            swz_addr[3:1] = word_addr[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;   // Single cycle strobe
            if (wr_en) begin
                prog_we <= ~in_prom;   // A new byte replaces a pending write
                prom_we <= in_prom & prom_fits;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog_data <= ioctl_dout;
            if (in_prom) begin
                prom_addr <= prom_ofs[10:0];
            end else begin
                prog_addr <= swz_addr;
                prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;  // Odd byte goes high
            end
        end
    end

endmodule

/* hdl/rom_slot.sv */
/* ROM read client with a one-word cache
   Raises a request on a miss and picks the byte for 8-bit clients */

`timescale 1ns/10ps

module rom_slot import kicker_pkg::*; #(
    parameter int DW     = 8,    // 8 or 16
    parameter int AW     = 16,
    parameter int OFFSET = 0     // SDRAM word offset of the region
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          clear,      // Cache invalid while downloading
    input  logic          cs,
    input  logic [AW-1:0] addr,
    input  word_t         data_read,
    input  logic          grant_rdy,  // data_rdy steered to this slot
    output logic          req,
    output sdram_addr_t   req_addr,
    output logic          ok,
    output logic [DW-1:0] dout
);

    // 8-bit clients address bytes, 16-bit ones address words
    localparam int SH  = (DW == 8) ? 1 : 0;
    localparam int WAW = AW - SH;

    logic [WAW-1:0] word_addr;
    logic [WAW-1:0] cached_addr;
    word_t          cached_word;
    logic           valid;
    logic           hit;

    assign word_addr = addr[AW-1:SH];
    assign hit       = valid && cached_addr == word_addr;

    assign ok       = cs & hit;
    assign req      = cs & ~hit;
    assign req_addr = sdram_addr_t'(OFFSET) + sdram_addr_t'(word_addr);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            valid <= 1'b0;
        end else if (grant_rdy) begin
            valid <= 1'b1;
        end
    end

    // Client holds addr until ok, so the tag is the current word address
    always_ff @(posedge clk) begin
        if (grant_rdy) begin
            cached_word <= data_read;
            cached_addr <= word_addr;
        end
    end

    generate
        if (DW == 8) begin : g_byte
            assign dout = addr[0] ? cached_word[15:8] : cached_word[7:0];
        end else begin : g_word
            assign dout = cached_word;
        end
    endgenerate

endmodule

/* run.sh */
#!/bin/sh
# Build and run the kicker memory plane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module kicker_mem_tb \
    -f sources.f -o kicker_mem_sim

./obj_dir/kicker_mem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* sources.f */
hdl/kicker_pkg.sv
hdl/frac_cen.sv
hdl/rom_dwnld.sv
hdl/rom_slot.sv
hdl/rom_arbiter.sv
hdl/kicker_mem.sv
tb/sdram_model.sv
tb/kicker_mem_tb.sv

/* tb/kicker_mem_tb.sv */
/* Testbench for the kicker memory plane
   Clock-enable rates, ROM download mapping, read-back, priority and cache hits */

`timescale 1ns/10ps

module kicker_mem_tb import kicker_pkg::*; ();

    localparam int SCR_START  = 'h10000;
    localparam int OBJ_START  = 'h14000;
    localparam int PROM_START = 'h34000;
    localparam int CEN_N      = 32;
    localparam int CEN_M      = 125;
    localparam int CEN_WINDOW = 1000;
    localparam int WAIT_LIMIT = 100;   // Cycles per wait
    localparam int NUM_LOADS  = 10;
    localparam int NUM_READS  = 8;

    typedef struct packed {
        ioctl_addr_t addr;
        byte_t       data;
        logic        prom;
        sdram_addr_t exp_addr;   // prog_addr or prom_addr in the low bits
        logic [1:0]  exp_mask;
    } load_entry_t;

    typedef struct packed {
        logic [1:0]  slot;
        logic [16:0] addr;
        logic        hit;        // Word already cached
        word_t       exp_data;
    } read_entry_t;

    logic        clk;
    logic        rst;
    cen_vec_t    cen;
    logic        downloading;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_dout;
    logic        ioctl_wr;
    sdram_addr_t prog_addr;
    byte_t       prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic        prom_we;
    prom_addr_t  prom_addr;
    logic        slot0_cs;
    logic [12:0] slot0_addr;
    logic        slot0_ok;
    word_t       slot0_dout;
    logic        slot1_cs;
    logic [16:0] slot1_addr;
    logic        slot1_ok;
    byte_t       slot1_dout;
    logic        slot2_cs;
    logic [15:0] slot2_addr;
    logic        slot2_ok;
    byte_t       slot2_dout;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_ack;
    logic        data_dst;
    logic        data_rdy;
    word_t       data_read;

    load_entry_t loads [NUM_LOADS];
    read_entry_t reads [NUM_READS];

    kicker_mem #(
        .SCR_START  ( SCR_START  ),
        .OBJ_START  ( OBJ_START  ),
        .PROM_START ( PROM_START ),
        .CEN_N      ( CEN_N      ),
        .CEN_M      ( CEN_M      )
    ) u_dut (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .cen         ( cen         ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   ),
        .slot0_cs    ( slot0_cs    ),
        .slot0_addr  ( slot0_addr  ),
        .slot0_ok    ( slot0_ok    ),
        .slot0_dout  ( slot0_dout  ),
        .slot1_cs    ( slot1_cs    ),
        .slot1_addr  ( slot1_addr  ),
        .slot1_ok    ( slot1_ok    ),
        .slot1_dout  ( slot1_dout  ),
        .slot2_cs    ( slot2_cs    ),
        .slot2_addr  ( slot2_addr  ),
        .slot2_ok    ( slot2_ok    ),
        .slot2_dout  ( slot2_dout  ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

    sdram_model #(.SEED(32'd87976)) u_sdram (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_dst   ( data_dst   ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic halt_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            halt_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic within_one(input int got, input int exp_val);
        return got >= exp_val - 1 && got <= exp_val + 1;
    endfunction

    // Outputs settle and inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_tables();
        // Main region without swizzle
        loads[0] = '{25'h0000010, 8'h12, 1'b0, 22'h000008, 2'b10};
        loads[1] = '{25'h0000011, 8'h34, 1'b0, 22'h000008, 2'b01};
        loads[2] = '{25'h0000102, 8'h5a, 1'b0, 22'h000081, 2'b10};
        // Scroll region turns nibble 3 into 7 and c into 8
        loads[3] = '{25'h0010006, 8'ha1, 1'b0, 22'h008007, 2'b10};
        loads[4] = '{25'h0010007, 8'hb2, 1'b0, 22'h008007, 2'b01};
        loads[5] = '{25'h0010018, 8'hc3, 1'b0, 22'h008008, 2'b10};
        loads[6] = '{25'h0014021, 8'hd4, 1'b0, 22'h00a010, 2'b01};
        loads[7] = '{25'h0014020, 8'he5, 1'b0, 22'h00a010, 2'b10};
        loads[8] = '{25'h0034000, 8'h0f, 1'b1, 22'h000000, 2'b00};   // Colour PROM
        loads[9] = '{25'h0034123, 8'h07, 1'b1, 22'h000123, 2'b00};
        reads[0] = '{2'd2, 17'h00010, 1'b0, 16'h0012};
        reads[1] = '{2'd2, 17'h00011, 1'b1, 16'h0034};
        reads[2] = '{2'd2, 17'h00102, 1'b0, 16'h005a};
        reads[3] = '{2'd0, 17'h00007, 1'b0, 16'hb2a1};
        reads[4] = '{2'd0, 17'h00008, 1'b0, 16'h00c3};
        reads[5] = '{2'd1, 17'h00021, 1'b0, 16'h00d4};
        reads[6] = '{2'd1, 17'h00020, 1'b1, 16'h00e5};
        reads[7] = '{2'd2, 17'h00200, 1'b0, 16'h0000};   // Never written
    endtask

    task automatic drive_slot(input logic [1:0] s, input logic sel, input logic [16:0] a);
        case (s)
            2'd0: begin
                slot0_cs   = sel;
                slot0_addr = a[12:0];
            end
            2'd1: begin
                slot1_cs   = sel;
                slot1_addr = a;
            end
            default: begin
                slot2_cs   = sel;
                slot2_addr = a[15:0];
            end
        endcase
    endtask

    function automatic logic slot_ok(input logic [1:0] s);
        case (s)
            2'd0:    return slot0_ok;
            2'd1:    return slot1_ok;
            default: return slot2_ok;
        endcase
    endfunction

    function automatic word_t slot_dout(input logic [1:0] s);
        case (s)
            2'd0:    return slot0_dout;
            2'd1:    return {8'h00, slot1_dout};
            default: return {8'h00, slot2_dout};
        endcase
    endfunction

    task automatic check_cen_rates();
        int   cnt [4];
        int   exp_cnt;
        int   b;
        logic prev0;
        for (b = 0; b < 4; b++) begin
            cnt[b] = 0;
        end
        prev0 = 1'b0;
        for (int c = 0; c < CEN_WINDOW; c++) begin
            next_cycle();
            for (b = 0; b < 4; b++) begin
                if (cen[b]) begin
                    cnt[b]++;
                end
            end
            assert (!(prev0 && cen[0])) else halt_run("cen[0] stayed high for two cycles");
            prev0 = cen[0];
        end
        for (b = 0; b < 4; b++) begin
            exp_cnt = CEN_WINDOW * CEN_N / (CEN_M << b);   // Each bit halves the rate
            assert (within_one(cnt[b], exp_cnt)) else begin
                halt_run($sformatf("Fail cen[%0d] count: got %h, expected %h within one",
                                   b, cnt[b], exp_cnt));
            end
        end
    endtask

    task automatic load_byte(input load_entry_t e);
        int i;
        next_cycle();
        ioctl_addr = e.addr;
        ioctl_dout = e.data;
        ioctl_wr   = 1'b1;
        next_cycle();
        ioctl_wr = 1'b0;
        check_value("prog_data", 32'(prog_data), 32'(e.data));
        if (e.prom) begin
            check_value("prom_we", 32'(prom_we), 32'd1);
            check_value("prom_addr", 32'(prom_addr), 32'(e.exp_addr[10:0]));
            check_value("prog_we", 32'(prog_we), 32'd0);
            next_cycle();
            check_value("prom_we", 32'(prom_we), 32'd0);   // One cycle only
            check_value("prog_we", 32'(prog_we), 32'd0);
        end else begin
            check_value("prog_we", 32'(prog_we), 32'd1);
            check_value("prog_addr", 32'(prog_addr), 32'(e.exp_addr));
            check_value("prog_mask", 32'(prog_mask), 32'(e.exp_mask));
            for (i = 0; i < WAIT_LIMIT && prog_we; i++) begin
                next_cycle();
            end
            assert (!prog_we) else halt_run("Timeout waiting for the SDRAM to ack a write");
        end
    endtask

    task automatic read_slot(input read_entry_t r);
        int i;
        next_cycle();
        drive_slot(r.slot, 1'b1, r.addr);
        #1;
        check_value($sformatf("slot%0d_ok", r.slot), 32'(slot_ok(r.slot)), 32'(r.hit));
        for (i = 0; i < WAIT_LIMIT && !slot_ok(r.slot); i++) begin
            next_cycle();
        end
        assert (slot_ok(r.slot)) else halt_run($sformatf("Timeout waiting for slot %0d", r.slot));
        check_value($sformatf("slot%0d_dout", r.slot), 32'(slot_dout(r.slot)), 32'(r.exp_data));
        if (r.hit) begin
            for (i = 0; i < 4; i++) begin   // Served from the cache
                next_cycle();
                check_value("sdram_req", 32'(sdram_req), 32'd0);
            end
        end
        next_cycle();
        drive_slot(r.slot, 1'b0, r.addr);
    endtask

    task automatic check_priority();
        sdram_addr_t seen [3];
        sdram_addr_t expect_addr [3];
        logic        req_prev;
        int          n;
        int          i;
        expect_addr[0] = 22'h000008;   // Main CPU byte 0x10
        expect_addr[1] = 22'h008007;   // Scroll word 7
        expect_addr[2] = 22'h00a020;   // Objects byte 0x40
        req_prev = 1'b0;
        n = 0;
        next_cycle();
        drive_slot(2'd0, 1'b1, 17'h00007);
        drive_slot(2'd1, 1'b1, 17'h00040);
        drive_slot(2'd2, 1'b1, 17'h00010);
        for (i = 0; i < 3 * WAIT_LIMIT && !(n == 3 && slot0_ok && slot1_ok && slot2_ok); i++) begin
            next_cycle();
            if (sdram_req && !req_prev) begin
                assert (n < 3) else halt_run("More SDRAM requests than missing slots");
                seen[n] = sdram_addr;
                n++;
            end
            req_prev = sdram_req;
        end
        assert (n == 3 && slot0_ok && slot1_ok && slot2_ok) else begin
            halt_run("Timeout waiting for the three slots to be served");
        end
        for (i = 0; i < 3; i++) begin
            check_value($sformatf("sdram_addr of request %0d", i), 32'(seen[i]),
                        32'(expect_addr[i]));
        end
        check_value("slot2_dout", 32'(slot2_dout), 32'h12);
        check_value("slot0_dout", 32'(slot0_dout), 32'hb2a1);
        check_value("slot1_dout", 32'(slot1_dout), 32'h00);
        next_cycle();
        drive_slot(2'd0, 1'b0, 17'h0);
        drive_slot(2'd1, 1'b0, 17'h0);
        drive_slot(2'd2, 1'b0, 17'h0);
    endtask

    initial begin
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        drive_slot(2'd0, 1'b0, 17'h0);
        drive_slot(2'd1, 1'b0, 17'h0);
        drive_slot(2'd2, 1'b0, 17'h0);
        fill_tables();
        repeat (10) next_cycle();
        check_value("{cen,sdram_req,prog_we,prom_we,slot ok}",
                    32'({cen, sdram_req, prog_we, prom_we, slot0_ok, slot1_ok, slot2_ok}), 32'd0);
        rst = 1'b0;
        check_cen_rates();
        next_cycle();
        downloading = 1'b1;
        for (int i = 0; i < NUM_LOADS; i++) begin
            load_byte(loads[i]);
        end
        next_cycle();
        downloading = 1'b0;
        for (int i = 0; i < NUM_READS; i++) begin
            read_slot(reads[i]);
        end
        check_priority();
        $display("Regression passed");
        $finish;
    end

endmodule

/* tb/sdram_model.sv */
/* Behavioural SDRAM for the kicker memory plane
   Masked programming writes and single-word read bursts after a random delay */

`timescale 1ns/10ps

module sdram_model import kicker_pkg::*; #(
    parameter logic [31:0] SEED = 32'd87976
) (
    input  logic        clk,
    input  logic        rst,
    input  sdram_addr_t prog_addr,
    input  byte_t       prog_data,
    input  logic [1:0]  prog_mask,
    input  logic        prog_we,
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    output logic        sdram_ack,
    output logic        data_dst,
    output logic        data_rdy,
    output word_t       data_read
);

    word_t       mem [sdram_addr_t];   // Sparse, unwritten words read as zero
    logic        ack_q  = 1'b0;
    logic        dst_q  = 1'b0;
    logic        rdy_q  = 1'b0;
    word_t       read_q = '0;
    logic        wr_wait;              // First cycle of a write seen
    logic        rd_busy;
    logic [2:0]  rd_wait;
    sdram_addr_t rd_addr;
    logic [31:0] rnd;

    assign sdram_ack = ack_q;
    assign data_dst  = dst_q;
    assign data_rdy  = rdy_q;
    assign data_read = read_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t read_word(input sdram_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return '0;
    endfunction

    // Mask is active low, bit 1 guards the upper byte
    function automatic word_t merge_byte(input word_t old, input byte_t b, input logic [1:0] m);
        word_t w;
        w = old;
        if (!m[0]) begin
            w[7:0] = b;
        end
        if (!m[1]) begin
            w[15:8] = b;
        end
        return w;
    endfunction

    always @(posedge clk) begin
        ack_q <= 1'b0;
        dst_q <= 1'b0;
        rdy_q <= 1'b0;
        if (rst) begin
            wr_wait <= 1'b0;
            rd_busy <= 1'b0;
            rd_wait <= '0;
            rnd     <= SEED;
        end else begin
            if (prog_we && !ack_q) begin
                if (wr_wait) begin   // Ack two cycles after prog_we rises
                    mem[prog_addr] = merge_byte(read_word(prog_addr), prog_data, prog_mask);
                    ack_q   <= 1'b1;
                    wr_wait <= 1'b0;
                end else begin
                    wr_wait <= 1'b1;
                end
            end else if (sdram_req && !rd_busy && !ack_q) begin
                ack_q   <= 1'b1;
                rd_busy <= 1'b1;
                rd_addr <= sdram_addr;
                rd_wait <= 3'(rnd % 32'd6) + 3'd1;   // 1 to 6 cycles
                rnd     <= xorshift32(rnd);
            end else if (rd_busy) begin
                if (rd_wait > 3'd1) begin
                    rd_wait <= rd_wait - 3'd1;
                end else if (rd_wait == 3'd1) begin
                    dst_q   <= 1'b1;
                    rd_wait <= 3'd0;
                end else begin
                    rdy_q   <= 1'b1;
                    read_q  <= read_word(rd_addr);
                    rd_busy <= 1'b0;
                end
            end
        end
    end

endmodule
